// File: project.f
+incdir+src
src/ahb_pkg.sv
src/cache_pkg.sv
src/transfer_handler.sv
src/tag_store.sv
src/line_refill.sv
src/ahb_read_cache.sv
test/ahb_mem_model.sv
test/cache_tb.sv

// File: src/ahb_pkg.sv
`include "cache_cfg.svh"

package ahb_pkg;

    // ******************************
    // AHB-Lite encodings
    // ******************************
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } ahb_htrans_e;

    // only single word transfers are issued downstream
    localparam logic [2:0] HSIZE_WORD = 3'b010;
    localparam logic       HRESP_OKAY = 1'b0;

    // master to slave, used on both sides of the cache
    typedef struct packed {
        logic [`ADDR_BITS-1:0] haddr;
        ahb_htrans_e           htrans;
        logic                  hwrite;
        logic [2:0]            hsize;
        logic [`DATA_BITS-1:0] hwdata;
    } ahb_req_t;

    // slave to master
    typedef struct packed {
        logic [`DATA_BITS-1:0] hrdata;
        logic                  hready;
        logic                  hresp;
    } ahb_rsp_t;

endpackage

// File: src/ahb_read_cache.sv
`timescale 1ns/1ns

module ahb_read_cache (
    input  logic              upstream_intf,
    input  logic              hrstn,
    input  ahb_pkg::ahb_req_t up_req,
    output ahb_pkg::ahb_rsp_t up_rsp,
    output ahb_pkg::ahb_req_t dn_req,
    input  ahb_pkg::ahb_rsp_t dn_rsp
);

    cache_pkg::cache_access_t cur_access;
    cache_pkg::lookup_t       lookup;
    logic                     stall;
    logic                     fill_en;
    cache_pkg::cache_index_t  fill_index;
    cache_pkg::cache_tag_t    fill_tag;
    cache_pkg::cache_line_t   fill_line;
    logic                     inval_en;
    cache_pkg::cache_index_t  inval_index;

    // ******************************
    // address phase
    // ******************************
    transfer_handler transfer_handler_i (
        .upstream_intf (upstream_intf),
        .hrstn         (hrstn),
        .up_req        (up_req),
        .stall         (stall),
        .cur_access    (cur_access)
    );

    // ******************************
    // lookup
    // ******************************
    tag_store tag_store_i (
        .upstream_intf (upstream_intf),
        .hrstn         (hrstn),
        .cur_access    (cur_access),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line),
        .inval_en      (inval_en),
        .inval_index   (inval_index),
        .lookup        (lookup)
    );

    // ******************************
    // miss and write handling
    // ******************************
    line_refill line_refill_i (
        .upstream_intf (upstream_intf),
        .hrstn         (hrstn),
        .lookup        (lookup),
        .dn_rsp        (dn_rsp),
        .dn_req        (dn_req),
        .up_rsp        (up_rsp),
        .stall         (stall),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line),
        .inval_en      (inval_en),
        .inval_index   (inval_index)
    );

endmodule

// File: src/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ******************************
// cache geometry
// ******************************
`define CACHE_SIZE_BYTES 1024
`define CACHE_LINE_BITS  128
`define LINE_COUNT       ((`CACHE_SIZE_BYTES * 8) / `CACHE_LINE_BITS)

// ******************************
// bus geometry
// ******************************
`define ADDR_BITS        32
`define DATA_BITS        32
`define WORDS_PER_LINE   (`CACHE_LINE_BITS / `DATA_BITS)

// the low two address bits select a byte inside a word
`define INDEX_BITS       6
`define OFFSET_BITS      2
`define TAG_BITS         (`ADDR_BITS - `INDEX_BITS - `OFFSET_BITS - 2)

`endif

// File: src/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    // ******************************
    // address fields
    // ******************************
    typedef logic [`TAG_BITS-1:0]        cache_tag_t;
    typedef logic [`INDEX_BITS-1:0]      cache_index_t;
    typedef logic [`OFFSET_BITS-1:0]     cache_offset_t;
    typedef logic [`DATA_BITS-1:0]       cache_word_t;
    typedef logic [`CACHE_LINE_BITS-1:0] cache_line_t;

    typedef struct packed {
        cache_tag_t    tag;
        cache_index_t  index;
        cache_offset_t offset;
        logic [1:0]    byte_sel;
    } cache_addr_t;

    // ******************************
    // storage and stage payloads
    // ******************************
    // valid bits live apart from the entry so they can be cleared on reset
    typedef struct packed {
        cache_tag_t  tag;
        cache_line_t line;
    } cache_entry_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        cache_addr_t addr;
        cache_word_t wdata;
    } cache_access_t;

    typedef struct packed {
        cache_access_t access;
        logic          hit;
        cache_word_t   word;
    } lookup_t;

endpackage

// File: src/line_refill.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module line_refill (
    input  logic                    upstream_intf,
    input  logic                    hrstn,
    input  cache_pkg::lookup_t      lookup,
    input  ahb_pkg::ahb_rsp_t       dn_rsp,
    output ahb_pkg::ahb_req_t       dn_req,
    output ahb_pkg::ahb_rsp_t       up_rsp,
    output logic                    stall,
    output logic                    fill_en,
    output cache_pkg::cache_index_t fill_index,
    output cache_pkg::cache_tag_t   fill_tag,
    output cache_pkg::cache_line_t  fill_line,
    output logic                    inval_en,
    output cache_pkg::cache_index_t inval_index
);

    typedef enum logic [2:0] {
        IDLE,
        REFILL_ADDR,
        REFILL_DATA,
        WRITE_ADDR,
        WRITE_DATA,
        RESPOND
    } state_e;

    state_e                  state;
    state_e                  next_state;
    cache_pkg::cache_offset_t beat;
    cache_pkg::cache_line_t  line_buf;
    cache_pkg::cache_addr_t  refill_addr;
    cache_pkg::cache_word_t  buf_word;
    logic                    busy_req;
    logic                    last_beat;

    // a new access that cannot be answered from the array
    assign busy_req = lookup.access.valid && (lookup.access.write || !lookup.hit);
    assign last_beat = (beat == cache_pkg::cache_offset_t'(`WORDS_PER_LINE - 1));

    // ******************************
    // FSM
    // ******************************
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (lookup.access.valid && lookup.access.write) begin
                    next_state = WRITE_ADDR;
                end else if (busy_req) begin
                    next_state = REFILL_ADDR;
                end
            end
            REFILL_ADDR: if (dn_rsp.hready) next_state = REFILL_DATA;
            REFILL_DATA: begin
                if (dn_rsp.hready) begin
                    next_state = last_beat ? RESPOND : REFILL_ADDR;
                end
            end
            WRITE_ADDR:  if (dn_rsp.hready) next_state = WRITE_DATA;
            WRITE_DATA:  if (dn_rsp.hready) next_state = RESPOND;
            default:     next_state = IDLE;
        endcase
    end

    always_ff @(posedge upstream_intf) begin
        if (!hrstn) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE) begin
                beat <= '0;
            end else if (state == REFILL_DATA && dn_rsp.hready) begin
                beat <= beat + 1'b1;
            end
        end
    end

    // each beat lands at its own offset in the line buffer
    always_ff @(posedge upstream_intf) begin
        if (state == REFILL_DATA && dn_rsp.hready) begin
            line_buf[beat * `DATA_BITS +: `DATA_BITS] <= dn_rsp.hrdata;
        end
    end

    // ******************************
    // downstream bus
    // ******************************
    always_comb begin
        refill_addr          = lookup.access.addr;
        refill_addr.offset   = beat;
        refill_addr.byte_sel = 2'b00;
    end

    // NONSEQ is driven only in the address states and every data state drives IDLE
    always_comb begin
        dn_req.haddr  = lookup.access.addr;
        dn_req.htrans = ahb_pkg::IDLE;
        dn_req.hwrite = 1'b0;
        dn_req.hsize  = ahb_pkg::HSIZE_WORD;
        dn_req.hwdata = lookup.access.wdata;
        case (state)
            REFILL_ADDR: begin
                dn_req.haddr  = refill_addr;
                dn_req.htrans = ahb_pkg::NONSEQ;
            end
            WRITE_ADDR: begin
                dn_req.htrans = ahb_pkg::NONSEQ;
                dn_req.hwrite = 1'b1;
            end
            default: ;
        endcase
    end

    // ******************************
    // upstream response and array updates
    // ******************************
    assign buf_word = line_buf[lookup.access.addr.offset * `DATA_BITS +: `DATA_BITS];

    always_comb begin
        up_rsp.hresp  = ahb_pkg::HRESP_OKAY;
        up_rsp.hrdata = (state == RESPOND) ? buf_word : lookup.word;
        case (state)
            IDLE:    up_rsp.hready = !busy_req;
            RESPOND: up_rsp.hready = 1'b1;
            default: up_rsp.hready = 1'b0;
        endcase
    end

    assign stall = !up_rsp.hready;

    // the line is written on the response edge, in time for the next access
    assign fill_en    = (state == RESPOND) && !lookup.access.write;
    assign fill_index = lookup.access.addr.index;
    assign fill_tag   = lookup.access.addr.tag;
    assign fill_line  = line_buf;

    assign inval_en = (state == IDLE) && lookup.access.valid &&
                      lookup.access.write && lookup.hit;
    assign inval_index = lookup.access.addr.index;

endmodule

// File: src/tag_store.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module tag_store (
    input  logic                     upstream_intf,
    input  logic                     hrstn,
    input  cache_pkg::cache_access_t cur_access,
    input  logic                     fill_en,
    input  cache_pkg::cache_index_t  fill_index,
    input  cache_pkg::cache_tag_t    fill_tag,
    input  cache_pkg::cache_line_t   fill_line,
    input  logic                     inval_en,
    input  cache_pkg::cache_index_t  inval_index,
    output cache_pkg::lookup_t       lookup
);

    logic [`LINE_COUNT-1:0]  valid_q;
    cache_pkg::cache_entry_t entries [`LINE_COUNT];
    cache_pkg::cache_entry_t rd_entry;
    logic                    hit;
    cache_pkg::cache_word_t  word;

    // ******************************
    // lookup
    // ******************************
    // purely combinational on the held access, so a hit answers in the
    // first data phase cycle
    assign rd_entry = entries[cur_access.addr.index];

    // an unwritten entry reads unknown, the valid bit masks that
    assign hit = valid_q[cur_access.addr.index] &&
                 (rd_entry.tag == cur_access.addr.tag);

    assign word = rd_entry.line[cur_access.addr.offset * `DATA_BITS +: `DATA_BITS];

    assign lookup = '{
        access: cur_access,
        hit:    hit,
        word:   word
    };

    // ******************************
    // updates
    // ******************************
    // line_refill never raises a fill and an invalidate in the same cycle
    always_ff @(posedge upstream_intf) begin
        if (!hrstn) begin
            valid_q <= '0;
        end else begin
            if (fill_en) begin
                valid_q[fill_index] <= 1'b1;
            end
            if (inval_en) begin
                valid_q[inval_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (fill_en) begin
            entries[fill_index] <= '{tag: fill_tag, line: fill_line};
        end
    end

endmodule

// File: src/transfer_handler.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module transfer_handler (
    input  logic                     upstream_intf,
    input  logic                     hrstn,
    input  ahb_pkg::ahb_req_t        up_req,
    input  logic                     stall,
    output cache_pkg::cache_access_t cur_access
);

    logic                   active;
    logic                   valid_q;
    logic                   write_q;
    cache_pkg::cache_addr_t addr_q;
    logic [`DATA_BITS-1:0]  wdata_q;

    // only NONSEQ and SEQ carry a transfer, IDLE and BUSY are dropped
    assign active = (up_req.htrans == ahb_pkg::NONSEQ) ||
                    (up_req.htrans == ahb_pkg::SEQ);

    // ******************************
    // address phase capture
    // ******************************
    // stall low means up_rsp.hready is high, so the address phase is accepted
    always_ff @(posedge upstream_intf) begin
        if (!hrstn) begin
            valid_q <= 1'b0;
            write_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= active;
            write_q <= active && up_req.hwrite;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (!stall) begin
            addr_q <= cache_pkg::cache_addr_t'(up_req.haddr);
        end
    end

    // ******************************
    // write data capture
    // ******************************
    // hwdata belongs to the data phase, one cycle after the address.
    // A write always stalls in that cycle and the master holds hwdata
    // until hready rises, so sampling during the stall is safe
    always_ff @(posedge upstream_intf) begin
        if (stall && write_q) begin
            wdata_q <= up_req.hwdata;
        end
    end

    assign cur_access = '{
        valid: valid_q,
        write: write_q,
        addr:  addr_q,
        wdata: wdata_q
    };

endmodule

// File: test/ahb_mem_model.sv
`timescale 1ns/1ns

module ahb_mem_model (
    input  logic              upstream_intf,
    input  logic              hrstn,
    input  ahb_pkg::ahb_req_t dn_req,
    output ahb_pkg::ahb_rsp_t dn_rsp
);

    // only written words are stored, everything else follows the fill rule
    logic [31:0] mem [logic [31:0]];
    integer      seed;
    logic [31:0] rnd;
    logic        dphase;
    logic        dwrite;
    logic [31:0] daddr;
    logic [31:0] rdata_q;
    logic [1:0]  waits;

    initial begin
        seed = 32'h87d6_dccd;
    end

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'h5a5a_0000;
    endfunction

    assign dn_rsp.hready = !dphase || (waits == 2'd0);
    assign dn_rsp.hresp  = 1'b0;
    assign dn_rsp.hrdata = rdata_q;

    // ******************************
    // address and data phases
    // ******************************
    always @(posedge upstream_intf) begin
        if (!hrstn) begin
            dphase <= 1'b0;
            waits  <= 2'd0;
        end else begin
            // a completing write lands before a new address reads the store
            if (dphase && dn_rsp.hready) begin
                if (dwrite) begin
                    mem[daddr] = dn_req.hwdata;
                end
                dphase <= 1'b0;
            end else if (dphase) begin
                waits <= waits - 2'd1;
            end
            if (dn_rsp.hready && dn_req.htrans == ahb_pkg::NONSEQ) begin
                rnd = $random(seed);
                dphase  <= 1'b1;
                dwrite  <= dn_req.hwrite;
                daddr   <= {dn_req.haddr[31:2], 2'b00};
                waits   <= rnd[1:0];
                rdata_q <= read_word({dn_req.haddr[31:2], 2'b00});
            end
        end
    end

endmodule

// File: test/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;

    localparam int RANDOM_ACCESSES = 300;
    // each access is budgeted as a worst case miss of 4 beats at up to 5 cycles plus overhead
    localparam int TIMEOUT_CYCLES = (RANDOM_ACCESSES + 40) * 24 + 200;

    logic              upstream_intf;
    logic              hrstn;
    ahb_pkg::ahb_req_t up_req;
    ahb_pkg::ahb_rsp_t up_rsp;
    ahb_pkg::ahb_req_t dn_req;
    ahb_pkg::ahb_rsp_t dn_rsp;

    integer      seed;
    logic [31:0] r;
    logic [31:0] mirror [logic [31:0]];
    logic        model_valid [64];
    logic [21:0] model_tag [64];
    logic [31:0] dn_addr_q [$];
    logic        dn_write_q [$];
    logic [31:0] dn_wdata_q [$];
    logic        pending;
    logic        pend_write;
    logic [31:0] pend_addr;
    int          pend_waits;
    logic        dn_dphase;
    logic        dn_dwrite;
    logic        run_started = 1'b0;
    int          error_count = 0;
    int          read_count = 0;
    int          write_count = 0;
    int          dn_total = 0;
    int          dn_expected = 0;
    int          cycle_count = 0;

    ahb_read_cache ahb_read_cache_i (
        .upstream_intf (upstream_intf),
        .hrstn         (hrstn),
        .up_req        (up_req),
        .up_rsp        (up_rsp),
        .dn_req        (dn_req),
        .dn_rsp        (dn_rsp)
    );

    ahb_mem_model ahb_mem_model_i (
        .upstream_intf (upstream_intf),
        .hrstn         (hrstn),
        .dn_req        (dn_req),
        .dn_rsp        (dn_rsp)
    );

    initial begin
        upstream_intf = 1'b0;
        forever #20 upstream_intf = ~upstream_intf;
    end

    // written words come from the mirror and all others from the memory fill rule
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (mirror.exists(a)) begin
            return mirror[a];
        end
        return a ^ 32'h5a5a_0000;
    endfunction

    // ******************************
    // checks per completed access
    // ******************************
    // index is address bits 9:4 and the tag is bits 31:10
    task automatic check_read();
        logic        hit_pred;
        logic [31:0] line_base;
        hit_pred  = model_valid[pend_addr[9:4]] &&
                    (model_tag[pend_addr[9:4]] == pend_addr[31:10]);
        line_base = {pend_addr[31:4], 4'h0};
        read_count++;
        if (!hit_pred) begin
            dn_expected += 4;
        end
        if (up_rsp.hrdata !== expected_word(pend_addr)) begin
            $display("error %0t ns: read 0x%08h returned 0x%08h, expected 0x%08h", $time,
                     pend_addr, up_rsp.hrdata, expected_word(pend_addr));
            error_count++;
        end
        if (hit_pred && (pend_waits != 0 || dn_addr_q.size() != 0)) begin
            $display("error %0t ns: hit on 0x%08h took %0d waits and %0d downstream transfers",
                     $time, pend_addr, pend_waits, dn_addr_q.size());
            error_count++;
        end
        if (!hit_pred && dn_addr_q.size() != 4) begin
            $display("error %0t ns: miss on 0x%08h caused %0d downstream transfers, expected 4",
                     $time, pend_addr, dn_addr_q.size());
            error_count++;
        end else if (!hit_pred) begin
            for (int i = 0; i < 4; i++) begin
                if (dn_addr_q[i] !== line_base + 4 * i || dn_write_q[i] !== 1'b0) begin
                    $display("error %0t ns: refill beat %0d read 0x%08h, expected 0x%08h",
                             $time, i, dn_addr_q[i], line_base + 4 * i);
                    error_count++;
                end
            end
        end
        model_valid[pend_addr[9:4]] = 1'b1;
        model_tag[pend_addr[9:4]]   = pend_addr[31:10];
    endtask

    task automatic check_write();
        write_count++;
        dn_expected++;
        if (dn_addr_q.size() != 1 || dn_wdata_q.size() != 1 || pend_waits == 0) begin
            $display("error %0t ns: write 0x%08h caused %0d downstream transfers in %0d waits",
                     $time, pend_addr, dn_addr_q.size(), pend_waits);
            error_count++;
        end else if (dn_addr_q[0] !== pend_addr || dn_write_q[0] !== 1'b1 ||
                     dn_wdata_q[0] !== up_req.hwdata) begin
            $display("error %0t ns: write went out as 0x%08h data 0x%08h, expected 0x%08h 0x%08h",
                     $time, dn_addr_q[0], dn_wdata_q[0], pend_addr, up_req.hwdata);
            error_count++;
        end
        mirror[{pend_addr[31:2], 2'b00}] = up_req.hwdata;
        if (model_tag[pend_addr[9:4]] == pend_addr[31:10]) begin
            model_valid[pend_addr[9:4]] = 1'b0;
        end
    endtask

    // ******************************
    // comparison process
    // ******************************
    always @(posedge upstream_intf) begin
        if (!hrstn) begin
            pending   = 1'b0;
            dn_dphase = 1'b0;
            foreach (model_valid[i]) model_valid[i] = 1'b0;
            dn_addr_q.delete();
            dn_write_q.delete();
            dn_wdata_q.delete();
            if (run_started && up_rsp.hready !== 1'b1) begin
                $display("hready was not high while the cache was held in reset");
                error_count++;
            end
        end else begin
            if (dn_dphase && dn_rsp.hready) begin
                if (dn_dwrite) dn_wdata_q.push_back(dn_req.hwdata);
                dn_dphase = 1'b0;
            end
            if (dn_req.htrans == ahb_pkg::NONSEQ && dn_rsp.hready) begin
                if (dn_req.hsize !== 3'b010) begin
                    $display("error %0t ns: downstream transfer to 0x%08h has hsize %0d",
                             $time, dn_req.haddr, dn_req.hsize);
                    error_count++;
                end
                dn_addr_q.push_back(dn_req.haddr);
                dn_write_q.push_back(dn_req.hwrite);
                dn_dphase = 1'b1;
                dn_dwrite = dn_req.hwrite;
                dn_total++;
            end
            if (pending && up_rsp.hready) begin
                if (up_rsp.hresp !== 1'b0) begin
                    $display("error %0t ns: response to 0x%08h was not OKAY", $time, pend_addr);
                    error_count++;
                end
                if (pend_write) check_write();
                else check_read();
                pending = 1'b0;
                dn_addr_q.delete();
                dn_write_q.delete();
                dn_wdata_q.delete();
            end else if (pending) begin
                pend_waits++;
            end
            if (up_rsp.hready && up_req.htrans == ahb_pkg::NONSEQ) begin
                pending    = 1'b1;
                pend_addr  = up_req.haddr;
                pend_write = up_req.hwrite;
                pend_waits = 0;
            end
        end
    end

    always @(posedge upstream_intf) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // ******************************
    // stimulus
    // ******************************
    task automatic apply_reset();
        hrstn = 1'b0;
        repeat (10) @(posedge upstream_intf);
        #2;
        hrstn = 1'b1;
    endtask

    // one access at a time, address phase then data phase until hready
    task automatic run_access(input logic [31:0] addr, input logic wr, input logic [31:0] wdata);
        up_req.haddr  = addr;
        up_req.htrans = ahb_pkg::NONSEQ;
        up_req.hwrite = wr;
        do @(posedge upstream_intf); while (up_rsp.hready !== 1'b1);
        #2;
        up_req.htrans = ahb_pkg::IDLE;
        up_req.hwrite = 1'b0;
        up_req.hwdata = wdata;
        do @(posedge upstream_intf); while (up_rsp.hready !== 1'b1);
        #2;
    endtask

    initial begin
        seed          = 32'h87d6_dccd;
        hrstn         = 1'b0;
        up_req        = '0;
        up_req.htrans = ahb_pkg::IDLE;
        up_req.hsize  = 3'b010;
        apply_reset();
        run_started = 1'b1;
        // cold read, then hits on the same line
        run_access(32'h0000_0124, 1'b0, 32'h0);
        run_access(32'h0000_0128, 1'b0, 32'h0);
        run_access(32'h0000_0124, 1'b0, 32'h0);
        // two tags on index 32 evict each other every time
        repeat (4) begin
            run_access(32'h0000_0200, 1'b0, 32'h0);
            run_access(32'h0000_0604, 1'b0, 32'h0);
        end
        run_access(32'h0000_0308, 1'b0, 32'h0);
        run_access(32'h0000_0308, 1'b1, 32'hdead_beef);
        run_access(32'h0000_0308, 1'b0, 32'h0);
        run_access(32'h0000_030c, 1'b0, 32'h0);
        // a reset while 0x124 is cached forces the next read to refetch
        run_access(32'h0000_0124, 1'b0, 32'h0);
        apply_reset();
        run_access(32'h0000_0124, 1'b0, 32'h0);
        // eight lines on four index values with two tags each
        repeat (RANDOM_ACCESSES) begin
            r = $random(seed);
            run_access(32'h0000_4000 | {r[4], 10'h0} | {r[3:2], 4'h0} | {r[1:0], 2'b00},
                       ($unsigned($random(seed)) % 100) >= 70, $random(seed));
        end
        repeat (2) @(posedge upstream_intf);
        if (dn_total != dn_expected) begin
            $display("error %0t ns: %0d downstream transfers in total, expected %0d",
                     $time, dn_total, dn_expected);
            error_count++;
        end
        $display("reads %0d, writes %0d, downstream transfers %0d, errors %0d",
                 read_count, write_count, dn_total, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
